//--- all.f
logic/spi_pkg.sv
logic/spi_sck_gen.sv
logic/spi_shifter.sv
logic/spi_arbiter.sv
logic/dac_writer.sv
logic/adc_poller.sv
logic/axi_lite_regs.sv
logic/spi_subsys_top.sv
tests/spi_dev_model.sv
tests/tb_spi_subsys.sv

//--- logic/adc_poller.sv
`timescale 1ns/1ps
`default_nettype none

module adc_poller #(
	parameter int POLL_CYCLES = 400
) (
	input wire CLK50MHZ,
	input wire RST,
	input wire poll_enable,
	input wire done,
	input wire spi_pkg::spi_rsp_t rsp,
	output spi_pkg::spi_req_t req,
	output logic req_valid,
	output logic [spi_pkg::ADC_RES_W-1:0] adc_result,
	output logic [15:0] adc_count
);
	import spi_pkg::*;

	localparam int POLL_W = (POLL_CYCLES > 1) ? $clog2(POLL_CYCLES) : 1;

	logic [POLL_W-1:0] poll_cnt;
	logic poll_due;

	assign poll_due = poll_enable && poll_cnt == POLL_W'(POLL_CYCLES - 1);

	// Fixed conversion frame, command in the top nibble
	always_comb begin
		req.frame.raw = '0;
		req.frame.raw[FRAME_W-1 -: 4] = ADC_CMD_CONVERT;
		req.dev = DEV_ADC;
	end

	//////////////////////////////////////////////////
	// Interval timer and request
	always_ff @(posedge CLK50MHZ) begin
		if (RST || !poll_enable)
			poll_cnt <= '0;
		else if (poll_due)
			poll_cnt <= '0;
		else
			poll_cnt <= poll_cnt + 1'b1;
	end

	// Skip the tick while a frame is outstanding
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			req_valid <= 1'b0;
		else if (done)
			req_valid <= 1'b0;
		else if (poll_due)
			req_valid <= 1'b1;
	end

	// Result from the low bits of the reply
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			adc_result <= '0;
			adc_count <= '0;
		end else if (done) begin
			adc_result <= rsp.data[ADC_RES_W-1:0];
			adc_count <= adc_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- logic/axi_lite_regs.sv
`timescale 1ns/1ps
`default_nettype none

module axi_lite_regs (
	input wire CLK50MHZ,
	input wire RST,
	input wire spi_pkg::axi_aw_t aw,
	input wire aw_valid,
	output logic aw_ready,
	input wire spi_pkg::axi_w_t w,
	input wire w_valid,
	output logic w_ready,
	output spi_pkg::axi_b_t b,
	output logic b_valid,
	input wire b_ready,
	input wire spi_pkg::axi_ar_t ar,
	input wire ar_valid,
	output logic ar_ready,
	output spi_pkg::axi_r_t r,
	output logic r_valid,
	input wire r_ready,
	output spi_pkg::dac_cmd_t dac_cmd,
	output logic dac_cmd_valid,
	output logic poll_enable,
	input wire dac_busy,
	input wire [spi_pkg::ADC_RES_W-1:0] adc_result,
	input wire [15:0] adc_count
);
	import spi_pkg::*;

	logic dac_pending;
	logic wr_fire;
	logic rd_fire;
	logic dac_stall;

	// Busy flag lags the command pulse by one cycle
	assign dac_pending = dac_busy || dac_cmd_valid;
	assign dac_stall = (aw.addr == REG_DAC_CMD) && dac_pending;

	assign wr_fire = aw_valid && aw_ready && w_valid && w_ready;
	assign rd_fire = ar_valid && ar_ready;

	//////////////////////////////////////////////////
	// Write channels
	// AW and W accepted together, one-cycle ready
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
		end else if (!aw_ready && aw_valid && w_valid && !b_valid && !dac_stall) begin
			aw_ready <= 1'b1;
			w_ready <= 1'b1;
		end else begin
			aw_ready <= 1'b0;
			w_ready <= 1'b0;
		end
	end

	// Register updates and B response
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			b_valid <= 1'b0;
			poll_enable <= 1'b0;
			dac_cmd_valid <= 1'b0;
		end else begin
			dac_cmd_valid <= 1'b0;
			if (b_valid && b_ready)
				b_valid <= 1'b0;
			if (wr_fire) begin
				b_valid <= 1'b1;
				b.resp <= AXI_RESP_OKAY;
				case (aw.addr)
					REG_CTRL:
						poll_enable <= w.data[0];
					REG_DAC_CMD:
						dac_cmd_valid <= 1'b1;
					// Read-only, write ignored
					REG_STATUS, REG_ADC_DATA: ;
					default:
						b.resp <= AXI_RESP_SLVERR;
				endcase
			end
		end
	end

	// DAC command payload
	always_ff @(posedge CLK50MHZ) begin
		if (wr_fire && aw.addr == REG_DAC_CMD) begin
			dac_cmd.channel <= w.data[19:16];
			dac_cmd.value <= w.data[15:0];
		end
	end

	//////////////////////////////////////////////////
	// Read channels
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			ar_ready <= 1'b0;
		else
			ar_ready <= !ar_ready && ar_valid && !r_valid;
	end

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			r_valid <= 1'b0;
		end else begin
			if (r_valid && r_ready)
				r_valid <= 1'b0;
			if (rd_fire) begin
				r_valid <= 1'b1;
				r.resp <= AXI_RESP_OKAY;
				case (ar.addr)
					REG_CTRL:
						r.data <= {31'd0, poll_enable};
					// Write-only, reads as zero
					REG_DAC_CMD:
						r.data <= '0;
					REG_STATUS:
						r.data <= {adc_count, 15'd0, dac_busy};
					REG_ADC_DATA:
						r.data <= {{(32 - ADC_RES_W){1'b0}}, adc_result};
					default: begin
						r.data <= '0;
						r.resp <= AXI_RESP_SLVERR;
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/dac_writer.sv
`timescale 1ns/1ps
`default_nettype none

module dac_writer (
	input wire CLK50MHZ,
	input wire RST,
	input wire spi_pkg::dac_cmd_t dac_cmd,
	input wire dac_cmd_valid,
	input wire done,
	output spi_pkg::spi_req_t req,
	output logic req_valid,
	output logic dac_busy
);
	import spi_pkg::*;

	logic take_cmd;

	assign take_cmd = dac_cmd_valid && !req_valid;

	// Request stays up until the frame ends
	always_ff @(posedge CLK50MHZ) begin
		if (RST)
			req_valid <= 1'b0;
		else if (done)
			req_valid <= 1'b0;
		else if (take_cmd)
			req_valid <= 1'b1;
	end

	// Frame built through the field view
	always_ff @(posedge CLK50MHZ) begin
		if (take_cmd) begin
			req.frame.dac.cmd <= DAC_CMD_WRITE_UPDATE;
			req.frame.dac.channel <= dac_cmd.channel;
			req.frame.dac.value <= dac_cmd.value;
			req.frame.dac.pad <= '0;
			req.dev <= DEV_DAC;
		end
	end

	assign dac_busy = req_valid;

endmodule

`default_nettype wire

//--- logic/spi_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_arbiter (
	input wire CLK50MHZ,
	input wire RST,
	input wire spi_pkg::spi_req_t dac_req,
	input wire dac_req_valid,
	input wire spi_pkg::spi_req_t adc_req,
	input wire adc_req_valid,
	input wire shifter_done,
	input wire spi_pkg::spi_rsp_t shifter_rsp,
	output logic dac_done,
	output logic adc_done,
	output spi_pkg::spi_rsp_t client_rsp,
	output logic shifter_start,
	output spi_pkg::spi_req_t shifter_req
);
	import spi_pkg::*;

	logic busy;
	logic last_gnt;
	logic pick;
	logic sel;

	// Round robin, skip the last winner on a tie
	always_comb begin
		if (dac_req_valid && adc_req_valid)
			pick = ~last_gnt;
		else if (adc_req_valid)
			pick = DEV_ADC;
		else
			pick = DEV_DAC;
	end

	// Grant held for the whole frame
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			busy <= 1'b0;
			// DAC wins the first tie
			last_gnt <= DEV_ADC;
		end else if (shifter_start) begin
			busy <= 1'b1;
			last_gnt <= pick;
		end else if (shifter_done) begin
			busy <= 1'b0;
		end
	end

	// Start only while the shifter sits idle
	assign shifter_start = !busy && (dac_req_valid || adc_req_valid);

	assign sel = busy ? last_gnt : pick;
	assign shifter_req = (sel == DEV_ADC) ? adc_req : dac_req;

	// Done goes back to the owner only
	assign dac_done = busy && shifter_done && last_gnt == DEV_DAC;
	assign adc_done = busy && shifter_done && last_gnt == DEV_ADC;
	assign client_rsp = shifter_rsp;

endmodule

`default_nettype wire

//--- logic/spi_pkg.sv
`default_nettype none

package spi_pkg;

	//////////////////////////////////////////////////
	// Frame and result widths
	localparam int FRAME_W = 32;
	localparam int ADC_RES_W = 12;

	// Device select, picks the chip select
	localparam logic DEV_DAC = 1'b0;
	localparam logic DEV_ADC = 1'b1;

	// Command nibbles, top of frame
	localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'h3;
	localparam logic [3:0] ADC_CMD_CONVERT = 4'h1;

	//////////////////////////////////////////////////
	// Register map, byte addresses
	localparam logic [3:0] REG_CTRL = 4'h0;
	localparam logic [3:0] REG_DAC_CMD = 4'h4;
	localparam logic [3:0] REG_STATUS = 4'h8;
	localparam logic [3:0] REG_ADC_DATA = 4'hC;

	// AXI response codes
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

	//////////////////////////////////////////////////
	// DAC frame layout, MSB first on the wire
	typedef struct packed {
		logic [3:0] cmd;
		logic [3:0] channel;
		logic [15:0] value;
		logic [7:0] pad;
	} dac_fields_t;

	// Raw view for the shifter, field view for the DAC writer
	typedef union packed {
		logic [FRAME_W-1:0] raw;
		dac_fields_t dac;
	} spi_frame_u;

	typedef struct packed {
		spi_frame_u frame;
		logic dev;
	} spi_req_t;

	typedef struct packed {
		logic [FRAME_W-1:0] data;
	} spi_rsp_t;

	// Host command towards the DAC writer
	typedef struct packed {
		logic [3:0] channel;
		logic [15:0] value;
	} dac_cmd_t;

	//////////////////////////////////////////////////
	// AXI4-Lite channel payloads
	typedef struct packed {
		logic [3:0] addr;
	} axi_aw_t;

	typedef struct packed {
		logic [31:0] data;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

	typedef struct packed {
		logic [3:0] addr;
	} axi_ar_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
	} axi_r_t;

endpackage

`default_nettype wire

//--- logic/spi_sck_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_sck_gen #(
	parameter int SCK_DIV = 2
) (
	input wire CLK50MHZ,
	input wire RST,
	input wire enable,
	output logic spi_sck,
	output logic shift_tick,
	output logic sample_tick
);
	// At least one counter bit for SCK_DIV of 1
	localparam int CNT_W = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;

	logic [CNT_W-1:0] half_cnt;
	logic sck_q;

	always_ff @(posedge CLK50MHZ) begin
		if (RST || !enable) begin
			half_cnt <= '0;
			sck_q <= 1'b0;
			shift_tick <= 1'b0;
			sample_tick <= 1'b0;
		end else begin
			shift_tick <= 1'b0;
			sample_tick <= 1'b0;
			if (half_cnt == CNT_W'(SCK_DIV - 1)) begin
				half_cnt <= '0;
				sck_q <= ~sck_q;
				// Ticks line up with the new SCK level
				sample_tick <= ~sck_q;
				shift_tick <= sck_q;
			end else begin
				half_cnt <= half_cnt + 1'b1;
			end
		end
	end

	// Idle low as soon as enable drops
	assign spi_sck = sck_q & enable;

endmodule

`default_nettype wire

//--- logic/spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter (
	input wire CLK50MHZ,
	input wire RST,
	input wire start,
	input wire spi_pkg::spi_req_t req,
	input wire shift_tick,
	input wire sample_tick,
	input wire spi_miso,
	output logic sck_enable,
	output logic spi_mosi,
	output logic spi_cs_dac_n,
	output logic spi_cs_adc_n,
	output logic done,
	output spi_pkg::spi_rsp_t rsp
);
	import spi_pkg::*;

	localparam int CNT_W = $clog2(FRAME_W);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SENDING,
		ST_DONE
	} state_t;

	state_t state;
	logic [FRAME_W-1:0] tx_shreg;
	logic [FRAME_W-1:0] rx_shreg;
	logic [CNT_W-1:0] bit_cnt;
	logic dev_q;
	logic sending;

	//////////////////////////////////////////////////
	// Frame FSM
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE:
					if (start)
						state <= ST_SENDING;
				// Leave on the last sample
				ST_SENDING:
					if (sample_tick && bit_cnt == CNT_W'(FRAME_W - 1))
						state <= ST_DONE;
				ST_DONE:
					state <= ST_IDLE;
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Sample counter, wraps back to zero at frame end
	always_ff @(posedge CLK50MHZ) begin
		if (RST || state == ST_IDLE)
			bit_cnt <= '0;
		else if (sending && sample_tick)
			bit_cnt <= bit_cnt + 1'b1;
	end

	//////////////////////////////////////////////////
	// Shift registers
	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_IDLE && start) begin
			tx_shreg <= req.frame.raw;
			dev_q <= req.dev;
		end else if (sending) begin
			// MOSI moves on falling SCK
			if (shift_tick)
				tx_shreg <= {tx_shreg[FRAME_W-2:0], 1'b0};
			// MISO taken on rising SCK
			if (sample_tick)
				rx_shreg <= {rx_shreg[FRAME_W-2:0], spi_miso};
		end
	end

	assign sending = (state == ST_SENDING);
	assign sck_enable = sending;
	// MSB valid before the first rising edge
	assign spi_mosi = sending & tx_shreg[FRAME_W-1];

	// Chip selects low only for the frame body
	assign spi_cs_dac_n = !(sending && dev_q == DEV_DAC);
	assign spi_cs_adc_n = !(sending && dev_q == DEV_ADC);

	assign done = (state == ST_DONE);
	assign rsp.data = rx_shreg;

endmodule

`default_nettype wire

//--- logic/spi_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_subsys_top #(
	parameter int SCK_DIV = 2,
	parameter int POLL_CYCLES = 400
) (
	input wire CLK50MHZ,
	input wire RST,
	input wire spi_pkg::axi_aw_t aw,
	input wire aw_valid,
	output logic aw_ready,
	input wire spi_pkg::axi_w_t w,
	input wire w_valid,
	output logic w_ready,
	output spi_pkg::axi_b_t b,
	output logic b_valid,
	input wire b_ready,
	input wire spi_pkg::axi_ar_t ar,
	input wire ar_valid,
	output logic ar_ready,
	output spi_pkg::axi_r_t r,
	output logic r_valid,
	input wire r_ready,
	output logic spi_sck,
	output logic spi_mosi,
	input wire spi_miso,
	output logic spi_cs_dac_n,
	output logic spi_cs_adc_n
);
	import spi_pkg::*;

	// Host side
	dac_cmd_t dac_cmd;
	logic dac_cmd_valid;
	logic dac_busy;
	logic poll_enable;
	logic [ADC_RES_W-1:0] adc_result;
	logic [15:0] adc_count;

	// Client side
	spi_req_t dac_req, adc_req, shifter_req;
	logic dac_req_valid, adc_req_valid;
	logic dac_done, adc_done;
	spi_rsp_t client_rsp, shifter_rsp;

	// Shifter side
	logic shifter_start, shifter_done;
	logic sck_enable, shift_tick, sample_tick;

	//////////////////////////////////////////////////
	axi_lite_regs regs_i (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w(w), .w_valid(w_valid), .w_ready(w_ready),
		.b(b), .b_valid(b_valid), .b_ready(b_ready),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.dac_cmd(dac_cmd), .dac_cmd_valid(dac_cmd_valid),
		.poll_enable(poll_enable), .dac_busy(dac_busy),
		.adc_result(adc_result), .adc_count(adc_count)
	);

	dac_writer dac_i (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.dac_cmd(dac_cmd), .dac_cmd_valid(dac_cmd_valid), .done(dac_done),
		.req(dac_req), .req_valid(dac_req_valid), .dac_busy(dac_busy)
	);

	adc_poller #(.POLL_CYCLES(POLL_CYCLES)) adc_i (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.poll_enable(poll_enable), .done(adc_done), .rsp(client_rsp),
		.req(adc_req), .req_valid(adc_req_valid),
		.adc_result(adc_result), .adc_count(adc_count)
	);

	// Both clients share one frame engine
	spi_arbiter arb_i (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.dac_req(dac_req), .dac_req_valid(dac_req_valid),
		.adc_req(adc_req), .adc_req_valid(adc_req_valid),
		.shifter_done(shifter_done), .shifter_rsp(shifter_rsp),
		.dac_done(dac_done), .adc_done(adc_done), .client_rsp(client_rsp),
		.shifter_start(shifter_start), .shifter_req(shifter_req)
	);

	spi_shifter shifter_i (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.start(shifter_start), .req(shifter_req),
		.shift_tick(shift_tick), .sample_tick(sample_tick), .spi_miso(spi_miso),
		.sck_enable(sck_enable), .spi_mosi(spi_mosi),
		.spi_cs_dac_n(spi_cs_dac_n), .spi_cs_adc_n(spi_cs_adc_n),
		.done(shifter_done), .rsp(shifter_rsp)
	);

	spi_sck_gen #(.SCK_DIV(SCK_DIV)) sck_i (
		.CLK50MHZ(CLK50MHZ), .RST(RST), .enable(sck_enable),
		.spi_sck(spi_sck), .shift_tick(shift_tick), .sample_tick(sample_tick)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_spi_subsys \
	--Mdir obj_dir \
	-f all.f

./obj_dir/Vtb_spi_subsys > sim.log
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
	echo "Simulation run OK"
else
	echo "Simulation run reported failure"
	exit 1
fi

//--- tests/spi_dev_model.sv
`timescale 1ns/1ps
`default_nettype none

module spi_dev_model (
	input wire spi_sck,
	input wire spi_mosi,
	input wire spi_cs_dac_n,
	input wire spi_cs_adc_n,
	output wire spi_miso,
	input wire [31:0] adc_response,
	output logic [31:0] dac_frame,
	output logic [7:0] dac_bits,
	output wire [15:0] dac_frames,
	output logic [31:0] adc_sent,
	output wire [15:0] adc_frames
);
	logic [31:0] dac_shreg = '0;
	logic [7:0] dac_cnt = '0;
	logic [15:0] dac_count = '0;
	logic [31:0] adc_latched = '0;
	logic [4:0] fall_cnt = '0;
	logic [15:0] adc_count = '0;

	//////////////////////////////////////////////////
	// DAC side
	// MOSI taken on rising SCK, count cleared while deselected
	always @(posedge spi_sck or posedge spi_cs_dac_n) begin
		if (spi_cs_dac_n) begin
			dac_cnt <= '0;
		end else begin
			dac_shreg <= {dac_shreg[30:0], spi_mosi};
			dac_cnt <= dac_cnt + 8'd1;
		end
	end

	// Frame closes on CS rise
	// Empty guard skips the CS settling at reset
	always @(posedge spi_cs_dac_n) begin
		if (dac_cnt != 8'd0) begin
			dac_frame <= dac_shreg;
			dac_bits <= dac_cnt;
			dac_count <= dac_count + 16'd1;
		end
	end

	//////////////////////////////////////////////////
	// ADC side
	// Response frozen for the whole frame
	always @(negedge spi_cs_adc_n)
		adc_latched <= adc_response;

	// Falling SCK moves to the next bit
	always @(negedge spi_sck or posedge spi_cs_adc_n) begin
		if (spi_cs_adc_n)
			fall_cnt <= '0;
		else
			fall_cnt <= fall_cnt + 5'd1;
	end

	always @(posedge spi_cs_adc_n) begin
		if (fall_cnt != 5'd0) begin
			adc_sent <= adc_latched;
			adc_count <= adc_count + 16'd1;
		end
	end

	// MSB ready as soon as CS falls
	assign spi_miso = !spi_cs_adc_n && adc_latched[5'd31 - fall_cnt];

	assign dac_frames = dac_count;
	assign adc_frames = adc_count;

endmodule

`default_nettype wire

//--- tests/tb_spi_subsys.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_subsys;
	import spi_pkg::*;

	localparam int SCK_DIV = 2;
	localparam int POLL_CYCLES = 400;
	localparam int CLK_NS = 20;
	localparam int N_MIXED = 6;
	// DAC and ADC frames over all tests rounded up
	localparam int N_FRAMES = 20;
	localparam int FRAME_NS = FRAME_W * 2 * SCK_DIV * CLK_NS;
	// Margin covers the poll intervals spent waiting
	localparam int MARGIN_NS = 12 * POLL_CYCLES * CLK_NS;
	localparam int WATCHDOG_NS = N_FRAMES * FRAME_NS + MARGIN_NS;
	localparam int HS_TIMEOUT = 1000;
	localparam int FRAME_TIMEOUT = 2 * POLL_CYCLES + 4 * FRAME_W * SCK_DIV;
	localparam int QUIET_CYCLES = 4 * FRAME_W * SCK_DIV;

	logic CLK50MHZ;
	logic RST;
	axi_aw_t aw;
	logic aw_valid;
	logic aw_ready;
	axi_w_t w;
	logic w_valid;
	logic w_ready;
	axi_b_t b;
	logic b_valid;
	logic b_ready;
	axi_ar_t ar;
	logic ar_valid;
	logic ar_ready;
	axi_r_t r;
	logic r_valid;
	logic r_ready;
	logic spi_sck;
	logic spi_mosi;
	wire spi_miso;
	logic spi_cs_dac_n;
	logic spi_cs_adc_n;

	// Device model side
	logic [31:0] adc_response;
	logic [31:0] dac_frame;
	logic [7:0] dac_bits;
	logic [15:0] dac_frames;
	logic [31:0] adc_sent;
	logic [15:0] adc_frames;

	int value_errors = 0;
	int other_errors = 0;
	integer seed;
	logic [31:0] dac_expect[$];
	logic [15:0] dac_seen = '0;
	logic [15:0] accept_frames;

	spi_subsys_top #(
		.SCK_DIV(SCK_DIV),
		.POLL_CYCLES(POLL_CYCLES)
	) dut_i (
		.CLK50MHZ(CLK50MHZ), .RST(RST),
		.aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w(w), .w_valid(w_valid), .w_ready(w_ready),
		.b(b), .b_valid(b_valid), .b_ready(b_ready),
		.ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .r_ready(r_ready),
		.spi_sck(spi_sck), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
		.spi_cs_dac_n(spi_cs_dac_n), .spi_cs_adc_n(spi_cs_adc_n)
	);

	spi_dev_model model_i (
		.spi_sck(spi_sck), .spi_mosi(spi_mosi),
		.spi_cs_dac_n(spi_cs_dac_n), .spi_cs_adc_n(spi_cs_adc_n),
		.spi_miso(spi_miso), .adc_response(adc_response),
		.dac_frame(dac_frame), .dac_bits(dac_bits), .dac_frames(dac_frames),
		.adc_sent(adc_sent), .adc_frames(adc_frames)
	);

	// 50 MHz
	initial CLK50MHZ = 1'b0;
	always #(CLK_NS / 2) CLK50MHZ = ~CLK50MHZ;

	//////////////////////////////////////////////////
	// Checks and helpers
	task automatic check_word(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic report_hang(input string what);
		$display("Timeout at %0t ns: gave up waiting for %s", $time, what);
		other_errors++;
	endtask

	// Command nibble, channel, value and pad in wire order
	function automatic logic [31:0] dac_word(input logic [3:0] ch, input logic [15:0] val);
		return {DAC_CMD_WRITE_UPDATE, ch, val, 8'h00};
	endfunction

	// ADC result is the low bits of the reply
	function automatic logic [31:0] low_bits(input logic [31:0] word);
		return {{(32 - ADC_RES_W){1'b0}}, word[ADC_RES_W-1:0]};
	endfunction

	// AW and W handshakes before the B response
	task automatic write_reg(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		logic aw_hs;
		logic w_hs;
		@(negedge CLK50MHZ);
		aw.addr = addr;
		w.data = data;
		aw_valid = 1'b1;
		w_valid = 1'b1;
		n = 0;
		// Ready seen here is still up at the next rising edge
		while ((aw_valid || w_valid) && n < HS_TIMEOUT) begin
			aw_hs = aw_valid && aw_ready;
			w_hs = w_valid && w_ready;
			// DAC frames finished when the address got in
			if (aw_hs)
				accept_frames = dac_frames;
			@(negedge CLK50MHZ);
			if (aw_hs)
				aw_valid = 1'b0;
			if (w_hs)
				w_valid = 1'b0;
			n++;
		end
		if (aw_valid)
			report_hang("AWREADY");
		if (w_valid)
			report_hang("WREADY");
		aw_valid = 1'b0;
		w_valid = 1'b0;
		b_ready = 1'b1;
		n = 0;
		while (!b_valid && n < HS_TIMEOUT) begin
			@(negedge CLK50MHZ);
			n++;
		end
		if (!b_valid)
			report_hang("BVALID");
		resp = b.resp;
		@(negedge CLK50MHZ);
		b_ready = 1'b0;
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(negedge CLK50MHZ);
		ar.addr = addr;
		ar_valid = 1'b1;
		n = 0;
		while (!ar_ready && n < HS_TIMEOUT) begin
			@(negedge CLK50MHZ);
			n++;
		end
		if (!ar_ready)
			report_hang("ARREADY");
		@(negedge CLK50MHZ);
		ar_valid = 1'b0;
		r_ready = 1'b1;
		n = 0;
		while (!r_valid && n < HS_TIMEOUT) begin
			@(negedge CLK50MHZ);
			n++;
		end
		if (!r_valid)
			report_hang("RVALID");
		data = r.data;
		resp = r.resp;
		@(negedge CLK50MHZ);
		r_ready = 1'b0;
	endtask

	// Until the model has seen the given number of frames
	task automatic wait_frames(input logic adc, input logic [15:0] target);
		int n;
		n = 0;
		while ((adc ? adc_frames : dac_frames) < target && n < FRAME_TIMEOUT) begin
			@(negedge CLK50MHZ);
			n++;
		end
		if ((adc ? adc_frames : dac_frames) < target)
			report_hang(adc ? "an ADC frame" : "a DAC frame");
	endtask

	//////////////////////////////////////////////////
	// Bus monitors
	// Chip selects exclusive at all times
	always @(negedge CLK50MHZ) begin
		assert (spi_cs_dac_n || spi_cs_adc_n) else begin
			$display("Error at %0t ns: both chip selects low", $time);
			value_errors++;
		end
	end

	// Each finished DAC frame against the next written value
	always @(negedge CLK50MHZ) begin
		if (dac_frames != dac_seen) begin
			dac_seen = dac_seen + 16'd1;
			if (dac_expect.size() == 0) begin
				$display("DAC frame at %0t ns that no write asked for", $time);
				other_errors++;
			end else begin
				check_word("DAC frame", dac_frame, dac_expect.pop_front());
				check_word("SCK edges in DAC frame", 32'(dac_bits), 32'd32);
			end
		end
	end

	// Hang guard sized from the frame count and poll waits
	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, run stopped", WATCHDOG_NS);
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		$display("TESTS FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Stimulus
	initial begin : main
		logic [1:0] resp;
		logic [31:0] data;
		logic [3:0] ch;
		logic [15:0] val;
		logic [15:0] base;
		int i;
		seed = 32'h945b_1ad8;
		RST = 1'b1;
		aw = '0;
		aw_valid = 1'b0;
		w = '0;
		w_valid = 1'b0;
		b_ready = 1'b0;
		ar = '0;
		ar_valid = 1'b0;
		r_ready = 1'b0;
		adc_response = '0;
		repeat (3) @(posedge CLK50MHZ);
		@(negedge CLK50MHZ);
		RST = 1'b0;

		// Idle state out of reset
		check_word("CS pair after reset", {30'd0, spi_cs_dac_n, spi_cs_adc_n}, 32'd3);
		check_word("SCK after reset", 32'(spi_sck), 32'd0);
		check_word("BVALID/RVALID after reset", {30'd0, b_valid, r_valid}, 32'd0);
		read_reg(REG_STATUS, data, resp);
		check_word("STATUS after reset", data, 32'd0);

		// One DAC write and one frame with polling still off
		ch = 4'($random(seed));
		val = 16'($random(seed));
		base = dac_frames;
		dac_expect.push_back(dac_word(ch, val));
		write_reg(REG_DAC_CMD, {12'd0, ch, val}, resp);
		check_word("DAC write response", 32'(resp), 32'(AXI_RESP_OKAY));
		wait_frames(1'b0, base + 16'd1);
		// Quiet window where a stray second frame would land
		repeat (QUIET_CYCLES) @(negedge CLK50MHZ);
		check_word("DAC frames per write", 32'(dac_frames), 32'(base + 16'd1));
		check_word("ADC frames with polling off", 32'(adc_frames), 32'd0);

		// Polling on with a new reply for each conversion
		write_reg(REG_CTRL, 32'd1, resp);
		for (i = 0; i < 3; i++) begin
			adc_response = $random(seed);
			wait_frames(1'b1, adc_frames + 16'd1);
			read_reg(REG_ADC_DATA, data, resp);
			check_word("ADC result", data, low_bits(adc_sent));
			read_reg(REG_STATUS, data, resp);
			check_word("ADC sample count", {16'd0, data[31:16]}, {16'd0, adc_frames});
		end

		// DAC writes back to back while polling runs
		base = dac_frames;
		for (i = 0; i < N_MIXED; i++) begin
			ch = 4'($random(seed));
			val = 16'($random(seed));
			adc_response = $random(seed);
			dac_expect.push_back(dac_word(ch, val));
			write_reg(REG_DAC_CMD, {12'd0, ch, val}, resp);
			check_word("DAC write response", 32'(resp), 32'(AXI_RESP_OKAY));
		end
		wait_frames(1'b0, base + 16'(N_MIXED));
		wait_frames(1'b1, adc_frames + 16'd1);
		read_reg(REG_ADC_DATA, data, resp);
		check_word("ADC result after mixed traffic", data, low_bits(adc_sent));
		read_reg(REG_STATUS, data, resp);
		check_word("ADC count after mixed traffic", {16'd0, data[31:16]}, {16'd0, adc_frames});
		write_reg(REG_CTRL, 32'd0, resp);

		// Second command held off until the first frame ends
		base = dac_frames;
		ch = 4'($random(seed));
		val = 16'($random(seed));
		dac_expect.push_back(dac_word(ch, val));
		write_reg(REG_DAC_CMD, {12'd0, ch, val}, resp);
		read_reg(REG_STATUS, data, resp);
		check_word("DAC busy bit", {31'd0, data[0]}, 32'd1);
		ch = 4'($random(seed));
		val = 16'($random(seed));
		dac_expect.push_back(dac_word(ch, val));
		write_reg(REG_DAC_CMD, {12'd0, ch, val}, resp);
		check_word("DAC frames before second accept", 32'(accept_frames), 32'(base + 16'd1));
		wait_frames(1'b0, base + 16'd2);

		// Unmapped addresses
		write_reg(4'h6, 32'hffff_ffff, resp);
		check_word("Unmapped write response", 32'(resp), 32'(AXI_RESP_SLVERR));
		read_reg(REG_CTRL, data, resp);
		check_word("CTRL after unmapped write", data, 32'd0);
		read_reg(4'hA, data, resp);
		check_word("Unmapped read response", 32'(resp), 32'(AXI_RESP_SLVERR));
		check_word("Unmapped read data", data, 32'd0);
		repeat (QUIET_CYCLES) @(negedge CLK50MHZ);

		if (dac_expect.size() != 0) begin
			$display("%0d written DAC values never reached the bus", dac_expect.size());
			other_errors++;
		end
		$display("Errors: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
